/* common/eth_pkg.sv */
package eth_pkg;

    localparam int max_packet_bytes = 64;
    localparam int tx_slots = 4;
    localparam int rx_slots = 4;
    localparam int slot_w = 2;
    localparam int idx_w = $clog2(max_packet_bytes);  // byte index into one slot

    typedef logic [6:0] len_t;  // 0 to 64
    typedef logic [7:0] result_t;

    localparam logic [7:0] preamble_byte = 8'h55;
    localparam logic [7:0] sfd_byte = 8'hd5;
    localparam int preamble_count = 7;
    localparam int fcs_bytes = 4;
    localparam int gap_cycles = 12;

    localparam logic [31:0] crc_poly = 32'hedb88320;  // reflected 802.3 polynomial
    localparam logic [31:0] crc_init = 32'hffffffff;
    localparam logic [31:0] crc_residue = 32'hdebb20e3;

    typedef enum logic [2:0] {
        op_read,
        op_read_len,
        op_read_next,
        op_write,
        op_write_len,
        op_write_next
    } op_t;

    typedef enum logic [2:0] {
        tx_st_idle,
        tx_st_preamble,
        tx_st_sfd,
        tx_st_data,
        tx_st_fcs,
        tx_st_gap
    } tx_state_t;

    typedef enum logic [1:0] {
        rx_st_idle,
        rx_st_preamble,
        rx_st_data,
        rx_st_drop
    } rx_state_t;

    // one byte through the register, lsb first
    function automatic logic [31:0] next_crc(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'h000000, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ crc_poly) : (c >> 1);
        end
        return c;
    endfunction

endpackage

/* hdl/eth_packet_driver.sv */
`timescale 1ns/1ps

module eth_packet_driver (
    input  logic             clock,
    input  logic             reset,
    input  logic             start,
    input  eth_pkg::op_t     operation,
    input  eth_pkg::len_t    address,
    input  logic [7:0]       value,
    output logic             done,
    output eth_pkg::result_t result,
    output logic [7:0]       tx_data,
    output logic             tx_en,
    input  logic [7:0]       rx_data,
    input  logic             rx_dv,
    input  logic             rx_er
);

    logic             write_strobe;
    logic             write_len_strobe;
    logic             write_next_strobe;
    logic             read_strobe;
    logic             read_len_strobe;
    logic             read_next_strobe;
    eth_pkg::result_t tx_result;
    eth_pkg::result_t rx_result;

    logic             frame_ready;
    eth_pkg::len_t    frame_len;
    eth_pkg::len_t    rd_index;
    logic [7:0]       rd_data;
    logic             frame_sent;

    logic             wr_en;
    eth_pkg::len_t    wr_index;
    logic [7:0]       wr_data;
    logic             commit;
    eth_pkg::len_t    commit_len;

    host_cmd host_cmd_i (
        .clock(clock), .reset(reset), .start(start), .operation(operation),
        .tx_result(tx_result), .rx_result(rx_result), .done(done), .result(result),
        .write_strobe(write_strobe), .write_len_strobe(write_len_strobe),
        .write_next_strobe(write_next_strobe), .read_strobe(read_strobe),
        .read_len_strobe(read_len_strobe), .read_next_strobe(read_next_strobe)
    );

    tx_buffer tx_buffer_i (
        .clock(clock), .reset(reset), .write_strobe(write_strobe),
        .write_len_strobe(write_len_strobe), .write_next_strobe(write_next_strobe),
        .address(address), .value(value), .rd_index(rd_index), .frame_sent(frame_sent),
        .tx_result(tx_result), .frame_ready(frame_ready), .frame_len(frame_len),
        .rd_data(rd_data)
    );

    tx_framer tx_framer_i (
        .clock(clock), .reset(reset), .frame_ready(frame_ready), .frame_len(frame_len),
        .rd_data(rd_data), .rd_index(rd_index), .frame_sent(frame_sent),
        .tx_data(tx_data), .tx_en(tx_en)
    );

    rx_buffer rx_buffer_i (
        .clock(clock), .reset(reset), .read_strobe(read_strobe),
        .read_len_strobe(read_len_strobe), .read_next_strobe(read_next_strobe),
        .address(address), .wr_en(wr_en), .wr_index(wr_index), .wr_data(wr_data),
        .commit(commit), .commit_len(commit_len), .rx_result(rx_result)
    );

    rx_parser rx_parser_i (
        .clock(clock), .reset(reset), .rx_data(rx_data), .rx_dv(rx_dv), .rx_er(rx_er),
        .wr_en(wr_en), .wr_index(wr_index), .wr_data(wr_data), .commit(commit),
        .commit_len(commit_len)
    );

endmodule

/* hdl/host_cmd.sv */
`timescale 1ns/1ps

module host_cmd (
    input  logic             clock,
    input  logic             reset,
    input  logic             start,
    input  eth_pkg::op_t     operation,
    input  eth_pkg::result_t tx_result,
    input  eth_pkg::result_t rx_result,
    output logic             done,
    output eth_pkg::result_t result,
    output logic             write_strobe,
    output logic             write_len_strobe,
    output logic             write_next_strobe,
    output logic             read_strobe,
    output logic             read_len_strobe,
    output logic             read_next_strobe
);

    logic tx_op;

    assign write_strobe      = start && (operation == eth_pkg::op_write);
    assign write_len_strobe  = start && (operation == eth_pkg::op_write_len);
    assign write_next_strobe = start && (operation == eth_pkg::op_write_next);
    assign read_strobe       = start && (operation == eth_pkg::op_read);
    assign read_len_strobe   = start && (operation == eth_pkg::op_read_len);
    assign read_next_strobe  = start && (operation == eth_pkg::op_read_next);

    assign tx_op = write_strobe || write_len_strobe || write_next_strobe;

    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= start;  // fixed one cycle latency
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            result <= tx_op ? tx_result : rx_result;
        end
    end

    // a command completes before the host may issue the next one
    assert property (@(posedge clock) disable iff (reset)
        start |=> (done && !start) ##1 !done);

endmodule

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_eth_packet_driver -f verilog.f -o tb_sim; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

/* rx/rx_buffer.sv */
`timescale 1ns/1ps

module rx_buffer (
    input  logic             clock,
    input  logic             reset,
    input  logic             read_strobe,
    input  logic             read_len_strobe,
    input  logic             read_next_strobe,
    input  eth_pkg::len_t    address,
    input  logic             wr_en,
    input  eth_pkg::len_t    wr_index,
    input  logic [7:0]       wr_data,
    input  logic             commit,
    input  eth_pkg::len_t    commit_len,
    output eth_pkg::result_t rx_result
);

    logic [7:0]                 mem [eth_pkg::rx_slots][eth_pkg::max_packet_bytes];
    eth_pkg::len_t              slot_len [eth_pkg::rx_slots];
    logic [eth_pkg::slot_w-1:0] recv_ptr;  // last received slot
    logic [eth_pkg::slot_w-1:0] read_ptr;  // slot the host reads
    logic [eth_pkg::slot_w-1:0] fill_ptr;
    logic                       fill_free;
    logic                       have_next;

    assign fill_ptr  = recv_ptr + 1'b1;
    assign fill_free = (fill_ptr != read_ptr);  // never overwrite the slot being read
    assign have_next = (read_ptr != recv_ptr);

    always_comb begin
        rx_result = '0;
        if (read_strobe) begin
            if (address < slot_len[read_ptr]) begin
                rx_result = mem[read_ptr][address[eth_pkg::idx_w-1:0]];
            end
        end else if (read_len_strobe) begin
            rx_result = eth_pkg::result_t'(slot_len[read_ptr]);
        end else if (read_next_strobe) begin
            rx_result = eth_pkg::result_t'(!have_next);
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en && fill_free) begin
            mem[fill_ptr][wr_index[eth_pkg::idx_w-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            recv_ptr <= '0;
            read_ptr <= '0;
            for (int i = 0; i < eth_pkg::rx_slots; i++) begin
                slot_len[i] <= '0;
            end
        end else begin
            if (commit && fill_free) begin
                slot_len[fill_ptr] <= commit_len;
                recv_ptr <= fill_ptr;
            end
            if (read_next_strobe && have_next) begin
                read_ptr <= read_ptr + 1'b1;
            end
        end
    end

endmodule

/* rx/rx_parser.sv */
`timescale 1ns/1ps

module rx_parser (
    input  logic          clock,
    input  logic          reset,
    input  logic [7:0]    rx_data,
    input  logic          rx_dv,
    input  logic          rx_er,
    output logic          wr_en,
    output eth_pkg::len_t wr_index,
    output logic [7:0]    wr_data,
    output logic          commit,
    output eth_pkg::len_t commit_len
);

    eth_pkg::rx_state_t state;
    eth_pkg::len_t      cnt;
    logic [31:0]        crc;

    always_ff @(posedge clock) begin
        if (reset) begin
            state  <= eth_pkg::rx_st_idle;
            cnt    <= '0;
            wr_en  <= 1'b0;
            commit <= 1'b0;
        end else begin
            wr_en  <= 1'b0;
            commit <= 1'b0;
            case (state)
                eth_pkg::rx_st_idle: begin
                    if (rx_dv) begin
                        if (!rx_er && rx_data == eth_pkg::preamble_byte) begin
                            state <= eth_pkg::rx_st_preamble;
                            cnt   <= eth_pkg::len_t'(1);
                        end else begin
                            state <= eth_pkg::rx_st_drop;
                        end
                    end
                end
                eth_pkg::rx_st_preamble: begin
                    if (!rx_dv) begin
                        state <= eth_pkg::rx_st_idle;
                    end else if (rx_er) begin
                        state <= eth_pkg::rx_st_drop;
                    end else if (rx_data == eth_pkg::preamble_byte &&
                                 cnt < eth_pkg::len_t'(eth_pkg::preamble_count)) begin
                        cnt <= cnt + 1'b1;
                    end else if (rx_data == eth_pkg::sfd_byte &&
                                 cnt == eth_pkg::len_t'(eth_pkg::preamble_count)) begin
                        state <= eth_pkg::rx_st_data;
                        cnt   <= '0;
                        crc   <= eth_pkg::crc_init;
                    end else begin
                        state <= eth_pkg::rx_st_drop;
                    end
                end
                eth_pkg::rx_st_data: begin
                    if (!rx_dv) begin
                        state <= eth_pkg::rx_st_idle;
                        if (crc == eth_pkg::crc_residue &&
                            cnt >= eth_pkg::len_t'(eth_pkg::fcs_bytes)) begin
                            commit     <= 1'b1;
                            commit_len <= cnt - eth_pkg::len_t'(eth_pkg::fcs_bytes);
                        end
                    end else if (rx_er ||
                                 cnt == eth_pkg::len_t'(eth_pkg::max_packet_bytes +
                                                        eth_pkg::fcs_bytes)) begin
                        state <= eth_pkg::rx_st_drop;  // error or oversize
                    end else begin
                        crc <= eth_pkg::next_crc(crc, rx_data);
                        cnt <= cnt + 1'b1;
                        if (cnt < eth_pkg::len_t'(eth_pkg::max_packet_bytes)) begin
                            wr_en    <= 1'b1;  // trailing fcs bytes past capacity not stored
                            wr_index <= cnt;
                            wr_data  <= rx_data;
                        end
                    end
                end
                eth_pkg::rx_st_drop: begin
                    if (!rx_dv) begin
                        state <= eth_pkg::rx_st_idle;
                    end
                end
                default: state <= eth_pkg::rx_st_idle;
            endcase
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        wr_en |-> wr_index < eth_pkg::len_t'(eth_pkg::max_packet_bytes));

endmodule

/* tests/tb_eth_packet_driver.sv */
`timescale 1ns/1ps

module tb_eth_packet_driver;

    localparam int good_frames = 6;
    localparam int bad_frames = 2;
    localparam int empty_cmds = 12;
    // worst case per 64 byte frame is about 65 writes and 67 reads at 2 cycles each plus wire time
    localparam int cycle_limit = (good_frames + bad_frames) * 520 + empty_cmds * 30 + 100;

    logic             clock;
    logic             reset;
    logic             start;
    eth_pkg::op_t     operation;
    eth_pkg::len_t    address;
    logic [7:0]       value;
    logic             done;
    eth_pkg::result_t result;
    logic [7:0]       tx_data;
    logic             tx_en;
    logic [7:0]       rx_data;
    logic             rx_dv;
    logic             rx_er;

    integer     seed;
    int         cycles = 0;
    int         next_id = 0;
    int         accepted = 0;
    int         rejected = 0;
    int         frames_seen = 0;
    int         exp_ids [$];  // committed, not yet seen on GMII
    logic [7:0] payload [64][64];
    int         payload_len [64];
    logic       flip_req;
    logic       error_req;
    int         lb_index;
    logic       lb_en;
    logic [7:0] lb_data;
    logic [7:0] frame_buf [128];
    int         nbytes;
    int         idle_cycles;
    logic       in_frame;

    eth_packet_driver dut_i (
        .clock(clock), .reset(reset), .start(start), .operation(operation),
        .address(address), .value(value), .done(done), .result(result),
        .tx_data(tx_data), .tx_en(tx_en), .rx_data(rx_data), .rx_dv(rx_dv), .rx_er(rx_er)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: no result after %0d clock cycles", cycle_limit);
            $display("*** FAILED ***");
            $fatal(1, "simulation timeout");
        end
    end

    task automatic check_value(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run failed");
    endtask

    // reflected 802.3 CRC, one bit at a time
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc_in, input logic [7:0] d);
        logic [31:0] c;
        c = crc_in;
        for (int b = 0; b < 8; b++) begin
            if (c[0] ^ d[b]) begin
                c = (c >> 1) ^ 32'hedb88320;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // one register stage from GMII tx back to GMII rx
    always @(posedge clock) begin
        #1;
        if (reset || !lb_en) begin
            lb_index = 0;
            rx_dv = 1'b0;
            rx_er = 1'b0;
            rx_data = 8'h00;
        end else begin
            rx_dv = 1'b1;
            rx_data = lb_data;
            rx_er = 1'b0;
            if (lb_index == 10 && flip_req) begin
                rx_data = lb_data ^ 8'h10;  // payload byte 2
            end
            if (lb_index == 10 && error_req) begin
                rx_er = 1'b1;
            end
            lb_index++;
        end
        lb_en = tx_en;  // goes out on the next cycle
        lb_data = tx_data;
    end

    task automatic check_frame(input int count);
        int          id;
        int          len;
        logic [31:0] crc;
        if (exp_ids.size() == 0) begin
            fail_run("a frame appeared on GMII that was never committed");
        end else begin
            id = exp_ids.pop_front();
            len = payload_len[id];
            check_value("frame length", count,
                        len + eth_pkg::preamble_count + 1 + eth_pkg::fcs_bytes);
            for (int i = 0; i < eth_pkg::preamble_count; i++) begin
                check_value("tx_data preamble", int'(frame_buf[i]), 'h55);
            end
            check_value("tx_data sfd", int'(frame_buf[7]), 'hd5);
            crc = 32'hffffffff;
            for (int i = 0; i < len; i++) begin
                check_value("tx_data payload", int'(frame_buf[8 + i]), int'(payload[id][i]));
                crc = crc32_byte(crc, payload[id][i]);
            end
            crc = ~crc;
            for (int i = 0; i < eth_pkg::fcs_bytes; i++) begin
                check_value("tx_data fcs", int'(frame_buf[8 + len + i]), int'(crc[8*i +: 8]));
            end
        end
    endtask

    // GMII monitor, mid cycle
    always @(negedge clock) begin
        if (reset) begin
            in_frame = 1'b0;
            nbytes = 0;
            idle_cycles = 1000;
        end else if (tx_en) begin
            if (!in_frame && idle_cycles < eth_pkg::gap_cycles) begin
                fail_run("inter-frame gap on GMII is shorter than the minimum");
            end
            in_frame = 1'b1;
            if (nbytes < 128) begin
                frame_buf[nbytes] = tx_data;
            end
            nbytes++;
        end else begin
            if (in_frame) begin
                check_frame(nbytes);
                frames_seen++;
                in_frame = 1'b0;
                nbytes = 0;
                idle_cycles = 0;
            end
            idle_cycles++;
        end
    end

    task automatic host_op(input eth_pkg::op_t op, input int addr, input int val,
                           output int res);
        start = 1'b1;
        operation = op;
        address = eth_pkg::len_t'(addr);
        value = 8'(val);
        @(posedge clock);
        #1;
        start = 1'b0;
        while (!done) begin
            @(posedge clock);
            #1;
        end
        res = int'(result);
        @(posedge clock);  // done low again before next start
        #1;
    endtask

    task automatic build_packet(output int id);
        int len;
        int addr;
        int res;
        id = next_id % 64;
        next_id++;
        len = 3 + int'($unsigned($random(seed)) % 62);
        payload_len[id] = len;
        for (int a = 0; a < len; a++) begin
            payload[id][a] = 8'($random(seed));
            host_op(eth_pkg::op_write, a, int'(payload[id][a]), res);
            check_value("write result", res, 0);
        end
        addr = int'($unsigned($random(seed)) % len);
        payload[id][addr] = 8'($random(seed));  // overwrite below the top
        host_op(eth_pkg::op_write, addr, int'(payload[id][addr]), res);
        check_value("write result", res, 0);
        host_op(eth_pkg::op_write, eth_pkg::max_packet_bytes, 'hff, res);
        check_value("write result past capacity", res, 1);
        host_op(eth_pkg::op_write_len, 0, 0, res);
        check_value("write_len result", res, len);
    endtask

    task automatic commit_packet(input int id);
        int res;
        int full;
        full = (accepted - frames_seen >= eth_pkg::tx_slots - 1) ? 1 : 0;
        host_op(eth_pkg::op_write_next, 0, 0, res);
        check_value("write_next result", res, full);
        if (res == 0) begin
            exp_ids.push_back(id);
            accepted++;
        end else begin
            rejected++;
        end
    endtask

    task automatic wait_tx_idle();
        while (frames_seen < accepted) begin
            @(posedge clock);
            #1;
        end
        repeat (4) begin  // rx commit lands in here
            @(posedge clock);
            #1;
        end
    endtask

    task automatic read_back(input int id);
        int res;
        int len;
        len = payload_len[id];
        host_op(eth_pkg::op_read_next, 0, 0, res);
        check_value("read_next result", res, 0);
        host_op(eth_pkg::op_read_len, 0, 0, res);
        check_value("read_len result", res, len);
        for (int a = 0; a < len; a++) begin
            host_op(eth_pkg::op_read, a, 0, res);
            check_value("read result", res, int'(payload[id][a]));
        end
        host_op(eth_pkg::op_read, len, 0, res);
        check_value("read result past length", res, 0);
    endtask

    initial begin
        int id;
        int res;
        seed = 4696;
        reset = 1'b1;
        start = 1'b0;
        operation = eth_pkg::op_read;
        address = '0;
        value = 8'h00;
        rx_data = 8'h00;
        rx_dv = 1'b0;
        rx_er = 1'b0;
        flip_req = 1'b0;
        error_req = 1'b0;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;

        check_value("done", int'(done), 0);
        check_value("tx_en", int'(tx_en), 0);
        host_op(eth_pkg::op_read_next, 0, 0, res);
        check_value("read_next result on empty ring", res, 1);

        for (int n = 0; n < good_frames; n++) begin
            build_packet(id);
            commit_packet(id);
            wait_tx_idle();
            read_back(id);
        end

        for (int n = 0; n < bad_frames; n++) begin  // flipped byte, then rx_er
            build_packet(id);
            flip_req = (n == 0);
            error_req = (n == 1);
            commit_packet(id);
            wait_tx_idle();
            flip_req = 1'b0;
            error_req = 1'b0;
            host_op(eth_pkg::op_read_next, 0, 0, res);
            check_value("read_next result after bad frame", res, 1);
        end

        id = next_id % 64;
        next_id++;
        payload_len[id] = 0;
        for (int n = 0; n < empty_cmds; n++) begin
            commit_packet(id);
        end
        wait_tx_idle();
        repeat (40) @(posedge clock);

        if (exp_ids.size() == 0 && rejected > 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            fail_run("frames left unsent or the transmit ring never reported full");
        end
    end

endmodule

/* tx/tx_buffer.sv */
`timescale 1ns/1ps

module tx_buffer (
    input  logic             clock,
    input  logic             reset,
    input  logic             write_strobe,
    input  logic             write_len_strobe,
    input  logic             write_next_strobe,
    input  eth_pkg::len_t    address,
    input  logic [7:0]       value,
    input  eth_pkg::len_t    rd_index,
    input  logic             frame_sent,
    output eth_pkg::result_t tx_result,
    output logic             frame_ready,
    output eth_pkg::len_t    frame_len,
    output logic [7:0]       rd_data
);

    logic [7:0]                 mem [eth_pkg::tx_slots][eth_pkg::max_packet_bytes];
    eth_pkg::len_t              slot_len [eth_pkg::tx_slots];
    logic [eth_pkg::slot_w-1:0] fill_ptr;
    logic [eth_pkg::slot_w-1:0] head_ptr;
    logic [eth_pkg::slot_w-1:0] next_fill;
    logic                       addr_ok;
    logic                       ring_full;

    assign next_fill   = fill_ptr + 1'b1;
    assign ring_full   = (next_fill == head_ptr);  // keeps one slot open for filling
    assign addr_ok     = (address < eth_pkg::len_t'(eth_pkg::max_packet_bytes));
    assign frame_ready = (fill_ptr != head_ptr);
    assign frame_len   = slot_len[head_ptr];
    assign rd_data     = mem[head_ptr][rd_index[eth_pkg::idx_w-1:0]];

    always_comb begin
        tx_result = '0;
        if (write_strobe) begin
            tx_result = eth_pkg::result_t'(!addr_ok);
        end else if (write_len_strobe) begin
            tx_result = eth_pkg::result_t'(slot_len[fill_ptr]);
        end else if (write_next_strobe) begin
            tx_result = eth_pkg::result_t'(ring_full);
        end
    end

    always_ff @(posedge clock) begin
        if (write_strobe && addr_ok) begin
            mem[fill_ptr][address[eth_pkg::idx_w-1:0]] <= value;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            fill_ptr <= '0;
            head_ptr <= '0;
            for (int i = 0; i < eth_pkg::tx_slots; i++) begin
                slot_len[i] <= '0;
            end
        end else begin
            if (write_strobe && addr_ok && address >= slot_len[fill_ptr]) begin
                slot_len[fill_ptr] <= address + 1'b1;
            end
            if (write_next_strobe && !ring_full) begin
                fill_ptr <= next_fill;
                slot_len[next_fill] <= '0;  // new slot starts empty
            end
            if (frame_sent) begin
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

    // the framer only finishes a frame that the ring handed it
    assert property (@(posedge clock) disable iff (reset) frame_sent |-> frame_ready);

endmodule

/* tx/tx_framer.sv */
`timescale 1ns/1ps

module tx_framer (
    input  logic          clock,
    input  logic          reset,
    input  logic          frame_ready,
    input  eth_pkg::len_t frame_len,
    input  logic [7:0]    rd_data,
    output eth_pkg::len_t rd_index,
    output logic          frame_sent,
    output logic [7:0]    tx_data,
    output logic          tx_en
);

    eth_pkg::tx_state_t state;
    eth_pkg::len_t      cnt;
    logic [31:0]        crc;

    // state always names the byte currently on the wire
    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= eth_pkg::tx_st_idle;
            cnt        <= '0;
            rd_index   <= '0;
            frame_sent <= 1'b0;
            tx_data    <= '0;
            tx_en      <= 1'b0;
        end else begin
            frame_sent <= 1'b0;
            case (state)
                eth_pkg::tx_st_idle: begin
                    rd_index <= '0;
                    crc      <= eth_pkg::crc_init;
                    if (frame_ready) begin
                        state   <= eth_pkg::tx_st_preamble;
                        tx_en   <= 1'b1;
                        tx_data <= eth_pkg::preamble_byte;
                        cnt     <= eth_pkg::len_t'(1);
                    end
                end
                eth_pkg::tx_st_preamble: begin
                    if (cnt == eth_pkg::len_t'(eth_pkg::preamble_count)) begin
                        state   <= eth_pkg::tx_st_sfd;
                        tx_data <= eth_pkg::sfd_byte;
                    end else begin
                        tx_data <= eth_pkg::preamble_byte;
                        cnt     <= cnt + 1'b1;
                    end
                end
                eth_pkg::tx_st_sfd, eth_pkg::tx_st_data: begin
                    if (rd_index == frame_len) begin
                        state   <= eth_pkg::tx_st_fcs;
                        tx_data <= ~crc[7:0];  // lsb byte first
                        crc     <= crc >> 8;
                        cnt     <= eth_pkg::len_t'(1);
                    end else begin
                        state    <= eth_pkg::tx_st_data;
                        tx_data  <= rd_data;
                        crc      <= eth_pkg::next_crc(crc, rd_data);
                        rd_index <= rd_index + 1'b1;
                    end
                end
                eth_pkg::tx_st_fcs: begin
                    if (cnt == eth_pkg::len_t'(eth_pkg::fcs_bytes)) begin
                        state      <= eth_pkg::tx_st_gap;
                        tx_en      <= 1'b0;
                        tx_data    <= '0;
                        frame_sent <= 1'b1;
                        cnt        <= eth_pkg::len_t'(1);
                    end else begin
                        tx_data <= ~crc[7:0];
                        crc     <= crc >> 8;
                        cnt     <= cnt + 1'b1;
                    end
                end
                eth_pkg::tx_st_gap: begin
                    // idle adds the last gap cycle
                    if (cnt == eth_pkg::len_t'(eth_pkg::gap_cycles - 1)) begin
                        state <= eth_pkg::tx_st_idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= eth_pkg::tx_st_idle;
            endcase
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        tx_en == (state inside {eth_pkg::tx_st_preamble, eth_pkg::tx_st_sfd,
                                eth_pkg::tx_st_data, eth_pkg::tx_st_fcs}));

endmodule

/* verilog.f */
common/eth_pkg.sv
hdl/host_cmd.sv
tx/tx_buffer.sv
tx/tx_framer.sv
rx/rx_buffer.sv
rx/rx_parser.sv
hdl/eth_packet_driver.sv
tests/tb_eth_packet_driver.sv
